// ==== tb.f ====
src/fb_pkg.sv
src/line_fetch_fsm.sv
src/pixel_fifo.sv
src/video_timing.sv
src/frame_reader_top.sv
test/frame_reader_tb.sv

// ==== test/frame_reader_tb.sv ====
// Frame reader testbench
`timescale 1ns/1ps

module frame_reader_tb
  import fb_pkg::*;
;

  localparam int h_active = 8;
  localparam int v_active = 4;
  localparam int h_total = 64;
  localparam int v_total = 6;
  localparam int fifo_depth = 16;
  localparam addr_t base_addr = 32'h8000_0000;
  localparam addr_t stride = 32'd1280;
  localparam int stall_frame = 4;   // frame with slow memory
  localparam int last_frame = 6;    // syncs seen before the run ends
  localparam int stall_cycles = 60;
  localparam int ack_limit = 20;    // cycles for mem_req to drop after ack
  localparam int run_limit = 5000;

  logic   clk;
  logic   rst;
  logic   enable;
  addr_t  frame_base;
  addr_t  line_stride;
  logic   mem_req;
  addr_t  mem_addr;
  logic   mem_ack;
  pixel_t mem_data;
  pixel_t pixel;
  logic   hsync;
  logic   vsync;
  logic   ve;
  logic   underrun;

  int   n_checks = 0;
  int   n_errors = 0;
  int   addr_idx = 0;      // requests issued in this frame
  int   x_no = 0;          // model raster position
  int   line_no = 0;
  int   frame_no = 0;      // frame syncs seen
  int   underruns = 0;
  int   since_fall = 1000; // cycles since the last ve fall
  int   vsync_run = 0;
  int   wait_cycles;
  logic stall = 1'b0;
  logic stop_run = 1'b0;
  logic req_prev = 1'b0;
  logic ack_prev = 1'b0;
  logic ve_prev = 1'b0;
  logic vsync_prev = 1'b0;

  frame_reader_top #(
    .h_active   (h_active),
    .v_active   (v_active),
    .h_total    (h_total),
    .v_total    (v_total),
    .fifo_depth (fifo_depth)
  ) i_frame_reader_top (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .frame_base  (frame_base),
    .line_stride (line_stride),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_ack     (mem_ack),
    .mem_data    (mem_data),
    .pixel       (pixel),
    .hsync       (hsync),
    .vsync       (vsync),
    .ve          (ve),
    .underrun    (underrun)
  );

  always #50 clk = ~clk;  // 100 ns period

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // memory content hashed from every address bit
  function automatic pixel_t word_for_addr(input addr_t a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    return h;
  endfunction

  function automatic addr_t pixel_addr(input int line, input int x);
    return base_addr + addr_t'(line) * stride + addr_t'(x) * addr_t'(bytes_per_pixel);
  endfunction

  task automatic check_idle_outputs();
    check_eq(mem_req, 1'b0, "mem_req idle");
    check_eq(ve, 1'b0, "ve idle");
    check_eq(hsync, 1'b0, "hsync idle");
    check_eq(vsync, 1'b0, "vsync idle");
    check_eq(underrun, 1'b0, "underrun idle");
  endtask

  // four-phase memory slave with random latency
  task automatic respond_memory();
    addr_t held;
    int    delay;
    int    waited;
    forever
    begin
      @(posedge clk);
      #1;
      if (!rst && mem_req && !mem_ack)
      begin
        held  = mem_addr;
        delay = stall ? stall_cycles : $urandom_range(2, 0);
        repeat (delay)
        begin
          @(posedge clk);
          #1;
          check_eq(mem_addr, held, "mem_addr held while waiting for ack");
        end
        mem_data = word_for_addr(held);
        mem_ack  = 1'b1;
        waited   = 0;
        while (mem_req && waited < ack_limit)
        begin
          @(posedge clk);
          #1;
          waited++;
        end
        if (mem_req)
        begin
          n_errors++;
          $display("timeout: mem_req still high %0d cycles after mem_ack rose", waited);
          stop_run = 1'b1;
        end
        delay = $urandom_range(2, 0);  // ack release latency
        repeat (delay)
        begin
          @(posedge clk);
          #1;
        end
        mem_ack = 1'b0;
      end
    end
  endtask

  // scan-out model sampled mid-cycle
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (mem_req && !req_prev)
      begin
        check_eq(ack_prev, 1'b0, "mem_req rose before mem_ack fell");
        check_eq(mem_addr, pixel_addr(addr_idx / h_active, addr_idx % h_active), "request address");
        addr_idx++;
      end
      if (ve)
      begin
        if (frame_no > 0 && frame_no != stall_frame)
        begin
          check_eq(pixel, word_for_addr(pixel_addr(line_no, x_no)), "pixel data");
          check_eq(underrun, 1'b0, "underrun in normal frame");
        end
        if (underrun)
          underruns++;
        if (x_no == h_active - 1)
        begin
          if (frame_no == stall_frame && line_no == v_active - 1)
            stall = 1'b0;  // fast memory from the last visible pixel on
          x_no = 0;
          line_no++;
        end
        else
          x_no++;
      end
      else
        check_eq(pixel, 32'd0, "pixel outside active video");
      if (!ve && ve_prev)
      begin
        check_eq(x_no, 0, "ve cycles per line");  // a full line wraps the model back to 0
        since_fall = 0;
      end
      else if (since_fall < 1000)
        since_fall++;
      if (since_fall < h_total - h_active)  // blanking part of an active line
        check_eq(hsync, (since_fall >= 2 && since_fall <= 9), "hsync position");
      if (vsync)
        vsync_run++;
      if (!vsync && vsync_prev)
      begin
        check_eq(vsync_run, h_total, "vsync length");
        vsync_run = 0;
      end
      if (vsync && !vsync_prev)  // same cycle as the internal frame_sync
      begin
        check_eq(line_no, v_active, "active lines per frame");
        if (frame_no == stall_frame)
          check_eq(underruns > 0, 1'b1, "underrun during stalled frame");
        else
          check_eq(addr_idx, h_active * v_active, "requests per frame");
        addr_idx  = 0;
        x_no      = 0;
        line_no   = 0;
        underruns = 0;
        frame_no++;
        if (frame_no == stall_frame)
          stall = 1'b1;
      end
    end
    req_prev   = rst ? 1'b0 : mem_req;
    ack_prev   = rst ? 1'b0 : mem_ack;
    ve_prev    = rst ? 1'b0 : ve;
    vsync_prev = rst ? 1'b0 : vsync;
  end

  initial
  begin
    void'($urandom(32'hd000_b2ce));
    clk         = 1'b0;
    rst         = 1'b1;
    enable      = 1'b0;
    frame_base  = base_addr;  // static for the whole run
    line_stride = stride;
    mem_ack     = 1'b0;
    mem_data    = '0;
    fork
      respond_memory();
    join_none
    repeat (4)
    begin
      @(posedge clk);
      #1;
      check_idle_outputs();
    end
    rst = 1'b0;
    @(posedge clk);
    #1;
    check_idle_outputs();  // still disabled
    enable = 1'b1;
    wait_cycles = 0;
    while (frame_no < last_frame && !stop_run && wait_cycles < run_limit)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (wait_cycles >= run_limit)
    begin
      n_errors++;
      $display("timeout: only %0d frames seen after %0d cycles", frame_no, wait_cycles);
    end
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== src/frame_reader_top.sv ====
// Frame buffer scan-out top
`timescale 1ns/1ps

module frame_reader_top
  import fb_pkg::*;
#(
  parameter int h_active   = 8,   // visible pixels per line
  parameter int v_active   = 4,   // visible lines per frame
  parameter int h_total    = 64,  // clocks per line
  parameter int v_total    = 6,   // lines per frame
  parameter int fifo_depth = 16   // pixel fifo words
)
(
  input  logic   clk,
  input  logic   rst,
  input  logic   enable,
  input  addr_t  frame_base,
  input  addr_t  line_stride,
  output logic   mem_req,
  output addr_t  mem_addr,
  input  logic   mem_ack,
  input  pixel_t mem_data,
  output pixel_t pixel,
  output logic   hsync,
  output logic   vsync,
  output logic   ve,
  output logic   underrun
);

  logic   frame_sync;  // flushes the fifo and rewinds the fetcher
  logic   fifo_wr;
  pixel_t fifo_wdata;
  logic   fifo_rd;
  pixel_t fifo_rdata;
  logic   fifo_full;
  logic   fifo_empty;

  line_fetch_fsm #(
    .h_active (h_active),
    .v_active (v_active)
  ) i_line_fetch_fsm (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .frame_base  (frame_base),
    .line_stride (line_stride),
    .frame_sync  (frame_sync),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_ack     (mem_ack),
    .mem_data    (mem_data),
    .fifo_full   (fifo_full),
    .fifo_wr     (fifo_wr),
    .fifo_wdata  (fifo_wdata)
  );

  pixel_fifo #(
    .fifo_depth (fifo_depth)
  ) i_pixel_fifo (
    .clk   (clk),
    .rst   (rst),
    .flush (frame_sync),  // stale words dropped at each frame start
    .wr    (fifo_wr),
    .wdata (fifo_wdata),
    .rd    (fifo_rd),
    .rdata (fifo_rdata),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  video_timing #(
    .h_active (h_active),
    .v_active (v_active),
    .h_total  (h_total),
    .v_total  (v_total)
  ) i_video_timing (
    .clk        (clk),
    .rst        (rst),
    .enable     (enable),
    .fifo_rdata (fifo_rdata),
    .fifo_empty (fifo_empty),
    .fifo_rd    (fifo_rd),
    .frame_sync (frame_sync),
    .pixel      (pixel),
    .hsync      (hsync),
    .vsync      (vsync),
    .ve         (ve),
    .underrun   (underrun)
  );

endmodule

// ==== src/video_timing.sv ====
// Video timing generator
`timescale 1ns/1ps

module video_timing
  import fb_pkg::*;
#(
  parameter int h_active = 8,   // visible pixels per line
  parameter int v_active = 4,   // visible lines per frame
  parameter int h_total  = 64,  // clocks per line
  parameter int v_total  = 6    // lines per frame
)
(
  input  logic   clk,
  input  logic   rst,
  input  logic   enable,
  input  pixel_t fifo_rdata,
  input  logic   fifo_empty,
  output logic   fifo_rd,
  output logic   frame_sync,
  output pixel_t pixel,
  output logic   hsync,
  output logic   vsync,
  output logic   ve,
  output logic   underrun
);

  localparam int hw = (h_total > 1) ? $clog2(h_total) : 1;
  localparam int vw = (v_total > 1) ? $clog2(v_total) : 1;
  localparam logic [hw-1:0] h_last = hw'(h_total - 1);
  localparam logic [vw-1:0] v_last = vw'(v_total - 1);

  logic [hw-1:0] h;           // clock within line
  logic [vw-1:0] v;           // line within frame
  logic          active;      // decoded from the counters
  logic          hsync_next;
  logic          vsync_line;

  assign active     = enable && (int'(h) < h_active) && (int'(v) < v_active);
  // 8 clocks of hsync after a 2 clock front porch
  assign hsync_next = enable && (int'(h) >= h_active + 2) && (int'(h) <= h_active + 9);
  assign vsync_line = enable && (v == v_last);  // last line of the frame

  // raster counters parked at zero while disabled
  always_ff @(posedge clk)
  begin
    if (rst || !enable)
    begin
      h <= '0;
      v <= '0;
    end
    else if (h == h_last)
    begin
      h <= '0;
      v <= (v == v_last) ? '0 : v + 1'b1;
    end
    else
      h <= h + 1'b1;
  end

  // registered decode keeps all outputs one clock behind the counters
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ve         <= 1'b0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      frame_sync <= 1'b0;
    end
    else
    begin
      ve         <= active;
      hsync      <= hsync_next;
      vsync      <= vsync_line;
      frame_sync <= vsync_line && (h == '0);  // first clock of the vsync line
    end
  end

  assign fifo_rd  = ve && !fifo_empty;       // pop the head word it shows
  assign underrun = ve && fifo_empty;        // nothing to show and nothing consumed
  assign pixel    = fifo_rd ? fifo_rdata : '0;  // black outside active video

  // sync lies entirely in blanking
  a_hsync_blank: assert property (@(posedge clk) disable iff (rst) !(hsync && ve));

endmodule

// ==== src/pixel_fifo.sv ====
// Pixel word FIFO
`timescale 1ns/1ps

module pixel_fifo
  import fb_pkg::*;
#(
  parameter int fifo_depth = 16  // words
)
(
  input  logic   clk,
  input  logic   rst,
  input  logic   flush,
  input  logic   wr,
  input  pixel_t wdata,
  input  logic   rd,
  output pixel_t rdata,
  output logic   full,
  output logic   empty
);

  localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam logic [aw-1:0] ptr_last = aw'(fifo_depth - 1);
  localparam logic [aw:0] depth_c = (aw + 1)'(fifo_depth);

  pixel_t        mem [fifo_depth];  // word storage
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;             // one extra bit to tell full from empty
  logic          do_wr;
  logic          do_rd;

  // wrap at the depth, which need not be a power of two
  function automatic logic [aw-1:0] bump(input logic [aw-1:0] p);
    logic [aw-1:0] n;
    n = (p == ptr_last) ? '0 : p + 1'b1;
    return n;
  endfunction

  assign do_wr = wr && !full && !flush;
  assign do_rd = rd && !empty && !flush;
  assign full  = (count == depth_c);
  assign empty = (count == '0);
  assign rdata = mem[rd_ptr];  // show-ahead output of the head word

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk)
  begin
    if (rst || flush)
    begin
      wr_ptr <= '0;  // flush drops everything in one cycle
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= bump(wr_ptr);
      if (do_rd)
        rd_ptr <= bump(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // the fetcher holds off while full
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr |-> !full);

  // the timing side only reads a non-empty fifo
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd |-> !empty);

endmodule

// ==== src/line_fetch_fsm.sv ====
// Frame buffer line fetcher
`timescale 1ns/1ps

module line_fetch_fsm
  import fb_pkg::*;
#(
  parameter int h_active = 8,  // pixels per line
  parameter int v_active = 4   // lines per frame
)
(
  input  logic   clk,
  input  logic   rst,
  input  logic   enable,
  input  addr_t  frame_base,
  input  addr_t  line_stride,
  input  logic   frame_sync,
  output logic   mem_req,
  output addr_t  mem_addr,
  input  logic   mem_ack,
  input  pixel_t mem_data,
  input  logic   fifo_full,
  output logic   fifo_wr,
  output pixel_t fifo_wdata
);

  localparam int xw = (h_active > 1) ? $clog2(h_active) : 1;
  localparam int lw = (v_active > 1) ? $clog2(v_active) : 1;
  localparam logic [xw-1:0] x_last = xw'(h_active - 1);
  localparam logic [lw-1:0] line_last = lw'(v_active - 1);

  fetch_state_t  state;
  logic [xw-1:0] x;          // pixel within line
  logic [lw-1:0] line;       // line within frame
  addr_t         line_base;  // address of pixel 0 on the current line
  logic          done;       // whole frame fetched
  logic          discard;    // open request belongs to the previous frame
  logic          capture;
  logic          can_issue;
  logic          restart;

  assign capture   = (state == req_high) && mem_ack;  // data valid this cycle
  assign can_issue = enable && !done && !frame_sync;  // no launch on the sync cycle
  // back to line 0, pixel 0 on sync, or when disabled between transactions
  assign restart   = frame_sync || (!enable && (state == idle || state == hold));

  assign fifo_wr    = capture && !discard && !frame_sync;  // stale words never reach the fifo
  assign fifo_wdata = mem_data;

  // handshake sequencer
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= idle;
      mem_req  <= 1'b0;
      mem_addr <= '0;
    end
    else
    begin
      case (state)
        idle, hold:
        begin
          if (!enable)
            state <= idle;  // abandon a pending hold
          else if (can_issue)
          begin
            if (fifo_full)
              state <= hold;  // wait for the timing side to drain
            else
            begin
              mem_req  <= 1'b1;
              mem_addr <= line_base + addr_t'(x) * addr_t'(bytes_per_pixel);
              state    <= req_high;
            end
          end
        end
        req_high:
        begin
          if (mem_ack)
          begin
            mem_req <= 1'b0;  // low on the cycle after capture
            state   <= req_low;
          end
        end
        req_low:
        begin
          if (!mem_ack)
            state <= idle;  // transaction closed
        end
        default: state <= idle;
      endcase
    end
  end

  // frame walk advancing one step per word written
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      x         <= '0;
      line      <= '0;
      line_base <= '0;
      done      <= 1'b0;
    end
    else if (restart)
    begin
      x         <= '0;
      line      <= '0;
      line_base <= frame_base;  // picks up a new base each frame
      done      <= 1'b0;
    end
    else if (fifo_wr)
    begin
      if (x == x_last)
      begin
        x <= '0;
        if (line == line_last)
          done <= 1'b1;  // park until the next frame_sync
        else
        begin
          line      <= line + 1'b1;
          line_base <= line_base + line_stride;
        end
      end
      else
        x <= x + 1'b1;
    end
  end

  // a sync during the request phase marks that word stale
  always_ff @(posedge clk)
  begin
    if (rst)
      discard <= 1'b0;
    else if (capture)
      discard <= 1'b0;  // the handshake still completes normally
    else if (frame_sync && state == req_high)
      discard <= 1'b1;
  end

  // memory sees a steady address until it acknowledges
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req && !mem_ack) |=> $stable(mem_addr));

  // no new request until the previous ack has fallen
  a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> !$past(mem_ack));

endmodule

// ==== src/fb_pkg.sv ====
// Frame reader shared types
package fb_pkg;

  // byte address into the frame buffer
  typedef logic [31:0] addr_t;

  // one pixel word, 0RGB with the top byte unused
  typedef logic [31:0] pixel_t;

  // every pixel word is 4 bytes wide in memory
  parameter int unsigned bytes_per_pixel = 4;

  // line fetcher sequencer states
  typedef enum logic [1:0] {
    idle     = 2'd0,  // nothing to fetch, or disabled
    req_high = 2'd1,  // request out, waiting for ack to rise
    req_low  = 2'd2,  // request dropped, waiting for ack to fall
    hold     = 2'd3   // fifo full, request held back
  } fetch_state_t;

endpackage
